/* hdl/dot11_rx_pkg.sv */
package dot11_rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // byte stream and legacy SIGNAL field
    ////////////////////////////////////////////////////////////////////////////
    localparam int BYTE_W    = 8;
    localparam int LEN_W     = 12;
    localparam int RATE_W    = 4;
    localparam int SIG_W     = 24;
    localparam int SIG_BYTES = 3;

    // frame check sequence, 802.3 polynomial
    localparam int               FCS_W       = 32;
    localparam logic [FCS_W-1:0] FCS_POLY    = 32'h04c1_1db7;
    localparam logic [FCS_W-1:0] FCS_INIT    = 32'hffff_ffff;
    localparam logic [FCS_W-1:0] FCS_RESIDUE = 32'hc704_dd7b;

    // symbol count
    localparam int NSYM_W            = 15;
    localparam int NBIT_W            = 9;
    localparam int TBITS_W           = 16;
    localparam int SERVICE_TAIL_BITS = 22;

    ////////////////////////////////////////////////////////////////////////////
    // legacy rates
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [RATE_W-1:0] {
        RATE_6M  = 4'b1011,
        RATE_9M  = 4'b1111,
        RATE_12M = 4'b1010,
        RATE_18M = 4'b1110,
        RATE_24M = 4'b1001,
        RATE_36M = 4'b1101,
        RATE_48M = 4'b1000,
        RATE_54M = 4'b1100
    } rate_e;

    localparam int N_RATES = 8;

    // data bits per OFDM symbol, same order as rate_e
    localparam logic [NBIT_W-1:0] NDBPS_TABLE [N_RATES] = '{
        9'd24, 9'd36, 9'd48, 9'd72, 9'd96, 9'd144, 9'd192, 9'd216
    };

    typedef enum logic [2:0] {
        S_WAIT_START,
        S_SIGNAL,
        S_CHECK_SIGNAL,
        S_SIGNAL_ERROR,
        S_DECODE_DATA,
        S_DECODE_DONE
    } rx_state_e;

    typedef enum logic [2:0] {
        E_OK,
        E_PARITY_FAIL,
        E_WRONG_RSVD,
        E_WRONG_TAIL,
        E_UNSUPPORTED_RATE,
        E_WRONG_FCS
    } status_e;

    // position of a rate code in NDBPS_TABLE
    function automatic logic [2:0] rate_idx(input rate_e rate);
        logic [2:0] idx;
        case (rate)
            RATE_6M:  idx = 3'd0;
            RATE_9M:  idx = 3'd1;
            RATE_12M: idx = 3'd2;
            RATE_18M: idx = 3'd3;
            RATE_24M: idx = 3'd4;
            RATE_36M: idx = 3'd5;
            RATE_48M: idx = 3'd6;
            RATE_54M: idx = 3'd7;
            default:  idx = 3'd0;
        endcase
        return idx;
    endfunction

endpackage

/* hdl/signal_field_check.sv */
`timescale 1ns/1ps

module signal_field_check
    import dot11_rx_pkg::*;
(
    input  logic [SIG_W-1:0] signal_bits_i,
    output rate_e            rate_o,
    output logic [LEN_W-1:0] len_o,
    output status_e          status_o
);

    logic       parity_ok;
    logic       rsvd_bit;
    logic       rate_msb;
    logic [5:0] tail_bits;

    // legacy SIGNAL bit layout
    assign rate_o    = rate_e'(signal_bits_i[3:0]);
    assign rate_msb  = signal_bits_i[3];
    assign rsvd_bit  = signal_bits_i[4];
    assign len_o     = signal_bits_i[16:5];
    assign tail_bits = signal_bits_i[23:18];

    // even parity covers bits 17..0 including the parity bit
    assign parity_ok = ~^signal_bits_i[17:0];

    // first failing check wins
    always_comb begin
        if (!parity_ok) begin
            status_o = E_PARITY_FAIL;
        end else if (rsvd_bit) begin
            status_o = E_WRONG_RSVD;
        end else if (|tail_bits) begin
            status_o = E_WRONG_TAIL;
        end else if (!rate_msb) begin
            status_o = E_UNSUPPORTED_RATE;
        end else begin
            status_o = E_OK;
        end
    end

endmodule

/* hdl/rx_frame_ctrl.sv */
`timescale 1ns/1ps

module rx_frame_ctrl
    import dot11_rx_pkg::*;
(
    input  logic              clock,
    input  logic              equalizer_reset,
    input  logic              pkt_start_i,
    input  logic [BYTE_W-1:0] byte_i,
    input  logic              byte_strobe_i,
    input  logic              fcs_match_i,

    output logic              demod_is_ongoing_o,
    output logic              pkt_header_valid_o,
    output logic              pkt_header_valid_strobe_o,
    output logic              legacy_sig_stb_o,
    output rate_e             pkt_rate_o,
    output logic [LEN_W-1:0]  pkt_len_o,
    output status_e           status_o,

    output logic [BYTE_W-1:0] data_o,
    output logic              data_strobe_o,
    output logic [LEN_W-1:0]  byte_count_o,

    output logic              fcs_out_strobe_o,
    output logic              fcs_ok_o,
    output logic              fcs_clear_o,

    output logic              phy_start_o,
    output rate_e             phy_rate_o,
    output logic [LEN_W-1:0]  phy_len_o
);

    rx_state_e        state;
    logic [SIG_W-1:0] signal_bits;
    logic [1:0]       sig_cnt;
    rate_e            chk_rate;
    logic [LEN_W-1:0] chk_len;
    status_e          chk_status;
    logic             len_reached;

    signal_field_check u_sig_check (
        .signal_bits_i (signal_bits),
        .rate_o        (chk_rate),
        .len_o         (chk_len),
        .status_o      (chk_status)
    );

    // calculator samples the header registers on phy_start_o
    assign phy_rate_o = pkt_rate_o;
    assign phy_len_o  = pkt_len_o;

    assign len_reached = (byte_count_o >= pkt_len_o);

    ////////////////////////////////////////////////////////////////////////////
    // byte capture
    ////////////////////////////////////////////////////////////////////////////

    // first SIGNAL byte ends up in bits 7..0
    always_ff @(posedge clock) begin
        if (state == S_SIGNAL && byte_strobe_i) begin
            signal_bits <= {byte_i, signal_bits[SIG_W-1:BYTE_W]};
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_DECODE_DATA && byte_strobe_i) begin
            data_o <= byte_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // packet FSM
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            state                     <= S_WAIT_START;
            sig_cnt                   <= '0;
            demod_is_ongoing_o        <= 1'b0;
            pkt_header_valid_o        <= 1'b0;
            pkt_header_valid_strobe_o <= 1'b0;
            legacy_sig_stb_o          <= 1'b0;
            pkt_rate_o                <= RATE_6M;
            pkt_len_o                 <= '0;
            status_o                  <= E_OK;
            data_strobe_o             <= 1'b0;
            byte_count_o              <= '0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_ok_o                  <= 1'b0;
            fcs_clear_o               <= 1'b0;
            phy_start_o               <= 1'b0;
        end else begin
            // pulses default low
            pkt_header_valid_o        <= 1'b0;
            pkt_header_valid_strobe_o <= 1'b0;
            legacy_sig_stb_o          <= 1'b0;
            data_strobe_o             <= 1'b0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_clear_o               <= 1'b0;
            phy_start_o               <= 1'b0;

            case (state)
                S_WAIT_START: begin
                    if (pkt_start_i) begin
                        demod_is_ongoing_o <= 1'b1;
                        sig_cnt            <= '0;
                        state              <= S_SIGNAL;
                    end
                end

                S_SIGNAL: begin
                    if (byte_strobe_i) begin
                        sig_cnt <= sig_cnt + 1'b1;
                        if (sig_cnt == 2'(SIG_BYTES - 1)) begin
                            state <= S_CHECK_SIGNAL;
                        end
                    end
                end

                // signal_bits is complete here, verdict goes out next cycle
                S_CHECK_SIGNAL: begin
                    pkt_header_valid_strobe_o <= 1'b1;
                    status_o                  <= chk_status;
                    if (chk_status == E_OK) begin
                        pkt_header_valid_o <= 1'b1;
                        legacy_sig_stb_o   <= 1'b1;
                        pkt_rate_o         <= chk_rate;
                        pkt_len_o          <= chk_len;
                        byte_count_o       <= '0;
                        fcs_clear_o        <= 1'b1;
                        phy_start_o        <= 1'b1;
                        state              <= S_DECODE_DATA;
                    end else begin
                        state <= S_SIGNAL_ERROR;
                    end
                end

                S_SIGNAL_ERROR: begin
                    demod_is_ongoing_o <= 1'b0;
                    state              <= S_WAIT_START;
                end

                S_DECODE_DATA: begin
                    if (len_reached) begin
                        // CRC match already includes the byte forwarded this cycle
                        fcs_out_strobe_o <= 1'b1;
                        fcs_ok_o         <= fcs_match_i;
                        status_o         <= fcs_match_i ? E_OK : E_WRONG_FCS;
                        state            <= S_DECODE_DONE;
                    end else if (byte_strobe_i) begin
                        data_strobe_o <= 1'b1;
                        byte_count_o  <= byte_count_o + 1'b1;
                    end
                end

                S_DECODE_DONE: begin
                    demod_is_ongoing_o <= 1'b0;
                    fcs_ok_o           <= 1'b0;
                    state              <= S_WAIT_START;
                end

                default: begin
                    state <= S_WAIT_START;
                end
            endcase
        end
    end

endmodule

/* hdl/fcs_crc32.sv */
`timescale 1ns/1ps

module fcs_crc32
    import dot11_rx_pkg::*;
(
    input  logic              clock,
    input  logic              equalizer_reset,
    input  logic              fcs_clear_i,
    input  logic [BYTE_W-1:0] byte_i,
    input  logic              byte_strobe_i,
    output logic              fcs_match_o
);

    logic [FCS_W-1:0]  crc_q;
    logic [FCS_W-1:0]  crc_next;
    logic [BYTE_W-1:0] byte_rev;

    // one byte through the shift register, msb of data first
    function automatic logic [FCS_W-1:0] crc_step(input logic [FCS_W-1:0]  crc_in,
                                                  input logic [BYTE_W-1:0] data);
        logic [FCS_W-1:0] c;
        logic             fb;
        c = crc_in;
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            fb = c[FCS_W-1] ^ data[i];
            c  = {c[FCS_W-2:0], 1'b0};
            if (fb) begin
                c = c ^ FCS_POLY;
            end
        end
        return c;
    endfunction

    // bytes go over the air lsb first
    always_comb begin
        for (int b = 0; b < BYTE_W; b++) begin
            byte_rev[b] = byte_i[BYTE_W-1-b];
        end
    end

    assign crc_next = byte_strobe_i ? crc_step(crc_q, byte_rev) : crc_q;

    // compare after this cycle's byte
    assign fcs_match_o = (crc_next == FCS_RESIDUE);

    always_ff @(posedge clock) begin
        if (equalizer_reset || fcs_clear_i) begin
            crc_q <= FCS_INIT;
        end else begin
            crc_q <= crc_next;
        end
    end

endmodule

/* hdl/phy_len_calc.sv */
`timescale 1ns/1ps

module phy_len_calc
    import dot11_rx_pkg::*;
(
    input  logic              clock,
    input  logic              equalizer_reset,
    input  logic              phy_start_i,
    input  rate_e             rate_i,
    input  logic [LEN_W-1:0]  len_i,
    output logic [NSYM_W-1:0] n_ofdm_sym_o,
    output logic [NBIT_W-1:0] n_bit_in_last_sym_o,
    output logic              phy_len_valid_o
);

    logic               busy;
    logic               more_left;
    logic [TBITS_W-1:0] total_bits;
    logic [TBITS_W-1:0] bits_left;
    logic [NBIT_W-1:0]  ndbps;
    logic [NSYM_W-1:0]  sym_cnt;

    // service and tail bits plus the PSDU
    assign total_bits = TBITS_W'(SERVICE_TAIL_BITS) + TBITS_W'({len_i, 3'b000});

    // another full symbol still fits before the last one
    assign more_left = (bits_left > TBITS_W'(ndbps));

    ////////////////////////////////////////////////////////////////////////////
    // repeated subtraction, one symbol per cycle
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (phy_start_i) begin
            bits_left <= total_bits;
            ndbps     <= NDBPS_TABLE[rate_idx(rate_i)];
            sym_cnt   <= '0;
        end else if (busy && more_left) begin
            bits_left <= bits_left - TBITS_W'(ndbps);
            sym_cnt   <= sym_cnt + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            busy                <= 1'b0;
            phy_len_valid_o     <= 1'b0;
            n_ofdm_sym_o        <= '0;
            n_bit_in_last_sym_o <= '0;
        end else if (phy_start_i) begin
            busy            <= 1'b1;
            phy_len_valid_o <= 1'b0;
        end else if (busy && !more_left) begin
            // what is left fills the last symbol
            busy                <= 1'b0;
            phy_len_valid_o     <= 1'b1;
            n_ofdm_sym_o        <= sym_cnt + 1'b1;
            n_bit_in_last_sym_o <= bits_left[NBIT_W-1:0];
        end
    end

endmodule

/* hdl/dot11_rx_top.sv */
`timescale 1ns/1ps

module dot11_rx_top
    import dot11_rx_pkg::*;
(
    input  logic              clock,
    input  logic              equalizer_reset,
    input  logic              pkt_start_i,
    input  logic              byte_strobe_i,
    input  logic [BYTE_W-1:0] byte_i,

    // packet and status
    output logic              demod_is_ongoing_o,
    output logic              pkt_header_valid_o,
    output logic              pkt_header_valid_strobe_o,
    output logic              legacy_sig_stb_o,
    output rate_e             pkt_rate_o,
    output logic [LEN_W-1:0]  pkt_len_o,
    output status_e           status_o,

    // payload
    output logic [BYTE_W-1:0] data_o,
    output logic              data_strobe_o,
    output logic [LEN_W-1:0]  byte_count_o,

    // FCS
    output logic              fcs_out_strobe_o,
    output logic              fcs_ok_o,

    // symbol count
    output logic [NSYM_W-1:0] n_ofdm_sym_o,
    output logic [NBIT_W-1:0] n_bit_in_last_sym_o,
    output logic              phy_len_valid_o
);

    logic             fcs_clear;
    logic             fcs_match;
    logic             phy_start;
    rate_e            phy_rate;
    logic [LEN_W-1:0] phy_len;

    rx_frame_ctrl u_ctrl (
        .clock                     (clock),
        .equalizer_reset           (equalizer_reset),
        .pkt_start_i               (pkt_start_i),
        .byte_i                    (byte_i),
        .byte_strobe_i             (byte_strobe_i),
        .fcs_match_i               (fcs_match),
        .demod_is_ongoing_o        (demod_is_ongoing_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .legacy_sig_stb_o          (legacy_sig_stb_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .status_o                  (status_o),
        .data_o                    (data_o),
        .data_strobe_o             (data_strobe_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o),
        .fcs_clear_o               (fcs_clear),
        .phy_start_o               (phy_start),
        .phy_rate_o                (phy_rate),
        .phy_len_o                 (phy_len)
    );

    // CRC runs on the forwarded payload
    fcs_crc32 u_fcs (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .fcs_clear_i     (fcs_clear),
        .byte_i          (data_o),
        .byte_strobe_i   (data_strobe_o),
        .fcs_match_o     (fcs_match)
    );

    phy_len_calc u_phy_len (
        .clock               (clock),
        .equalizer_reset     (equalizer_reset),
        .phy_start_i         (phy_start),
        .rate_i              (phy_rate),
        .len_i               (phy_len),
        .n_ofdm_sym_o        (n_ofdm_sym_o),
        .n_bit_in_last_sym_o (n_bit_in_last_sym_o),
        .phy_len_valid_o     (phy_len_valid_o)
    );

endmodule

/* bench/dot11_rx_ref.svh */
`ifndef DOT11_RX_REF_SVH
`define DOT11_RX_REF_SVH

// rate code for each row of NDBPS_TABLE
function automatic rate_e rate_at(input int i);
    rate_e r;
    case (i)
        0: r = RATE_6M;
        1: r = RATE_9M;
        2: r = RATE_12M;
        3: r = RATE_18M;
        4: r = RATE_24M;
        5: r = RATE_36M;
        6: r = RATE_48M;
        default: r = RATE_54M;
    endcase
    return r;
endfunction

function automatic int ndbps_of(input rate_e r);
    int n;
    n = 0;
    for (int i = 0; i < N_RATES; i++) begin
        if (rate_at(i) == r) begin
            n = NDBPS_TABLE[i];
        end
    end
    return n;
endfunction

// reflected CRC-32, lsb of each byte first
function automatic logic [FCS_W-1:0] crc32_byte(input logic [FCS_W-1:0]  crc,
                                                input logic [BYTE_W-1:0] b);
    logic [FCS_W-1:0] c;
    c = crc ^ {24'h0, b};
    for (int i = 0; i < BYTE_W; i++) begin
        c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
    end
    return c;
endfunction

// legacy SIGNAL word, parity makes bits 17..0 even
function automatic logic [SIG_W-1:0] build_signal(input logic [RATE_W-1:0] rate,
                                                  input logic              rsvd,
                                                  input logic [LEN_W-1:0]  len,
                                                  input logic [5:0]        tail);
    logic par;
    par = ^{len, rsvd, rate};
    return {tail, par, len, rsvd, rate};
endfunction

function automatic logic [NSYM_W-1:0] ref_nsym(input rate_e r, input logic [LEN_W-1:0] len);
    int total;
    int n;
    total = SERVICE_TAIL_BITS + 8 * len;
    n     = ndbps_of(r);
    return NSYM_W'((total + n - 1) / n);
endfunction

function automatic logic [NBIT_W-1:0] ref_last_bits(input rate_e r,
                                                    input logic [LEN_W-1:0] len);
    int total;
    int n;
    int nsym;
    total = SERVICE_TAIL_BITS + 8 * len;
    n     = ndbps_of(r);
    nsym  = (total + n - 1) / n;
    return NBIT_W'(total - (nsym - 1) * n);
endfunction

`endif

/* bench/dot11_rx_tb.sv */
`timescale 1ns/1ps

module dot11_rx_tb
    import dot11_rx_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic              clock = 1'b0;
    logic              equalizer_reset;
    logic              pkt_start_i;
    logic              byte_strobe_i;
    logic [BYTE_W-1:0] byte_i;
    logic              demod_is_ongoing_o;
    logic              pkt_header_valid_o;
    logic              pkt_header_valid_strobe_o;
    logic              legacy_sig_stb_o;
    rate_e             pkt_rate_o;
    logic [LEN_W-1:0]  pkt_len_o;
    status_e           status_o;
    logic [BYTE_W-1:0] data_o;
    logic              data_strobe_o;
    logic [LEN_W-1:0]  byte_count_o;
    logic              fcs_out_strobe_o;
    logic              fcs_ok_o;
    logic [NSYM_W-1:0] n_ofdm_sym_o;
    logic [NBIT_W-1:0] n_bit_in_last_sym_o;
    logic              phy_len_valid_o;

    integer            seed;

    // current packet and what it should produce
    logic [BYTE_W-1:0] tx_bytes [$];
    logic [SIG_W-1:0]  tx_signal;
    status_e           exp_hdr_status;
    rate_e             exp_rate;
    logic [LEN_W-1:0]  exp_len;
    logic              exp_fcs_ok;

    `include "dot11_rx_ref.svh"

    always #10 clock = ~clock;

    dot11_rx_top dut (.*);

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_status(input string name, input status_e exp, input status_e act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_len(input string name, input logic [LEN_W-1:0] exp,
                             input logic [LEN_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_rate(input string name, input rate_e exp, input rate_e act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
                              input logic [BYTE_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_nsym(input string name, input logic [NSYM_W-1:0] exp,
                              input logic [NSYM_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_nbits(input string name, input logic [NBIT_W-1:0] exp,
                               input logic [NBIT_W-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR: %s expected %h got %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("ERROR: %s expected %h got %h", name, exp, act));
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // packet building and stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic make_good_frame(input rate_e r, input int n_data, input logic bad_fcs);
        logic [FCS_W-1:0]  crc;
        logic [BYTE_W-1:0] b;
        int                pos;
        tx_bytes.delete();
        crc = 32'hffff_ffff;
        for (int i = 0; i < n_data; i++) begin
            b = BYTE_W'($random(seed));
            tx_bytes.push_back(b);
            crc = crc32_byte(crc, b);
        end
        crc = ~crc;
        // FCS goes out little-endian
        for (int i = 0; i < 4; i++) begin
            tx_bytes.push_back(crc[i*8 +: 8]);
        end
        if (bad_fcs) begin
            pos = rand_range(0, n_data * 8 - 1);
            tx_bytes[pos / 8] = tx_bytes[pos / 8] ^ (8'h01 << (pos % 8));
        end
        exp_len        = LEN_W'(n_data + 4);
        exp_rate       = r;
        exp_hdr_status = E_OK;
        exp_fcs_ok     = !bad_fcs;
        tx_signal      = build_signal(r, 1'b0, exp_len, 6'd0);
    endtask

    task automatic make_bad_header(input int kind);
        rate_e r;
        r       = rate_at(rand_range(0, N_RATES - 1));
        exp_len = LEN_W'(rand_range(8, 44));
        tx_bytes.delete();
        case (kind)
            0: begin
                tx_signal      = build_signal(r, 1'b0, exp_len, 6'd0);
                tx_signal[17]  = ~tx_signal[17];
                exp_hdr_status = E_PARITY_FAIL;
            end
            1: begin
                tx_signal      = build_signal(r, 1'b1, exp_len, 6'd0);
                exp_hdr_status = E_WRONG_RSVD;
            end
            2: begin
                tx_signal      = build_signal(r, 1'b0, exp_len, 6'(1 << rand_range(0, 5)));
                exp_hdr_status = E_WRONG_TAIL;
            end
            default: begin
                tx_signal      = build_signal(4'(r) & 4'b0111, 1'b0, exp_len, 6'd0);
                exp_hdr_status = E_UNSUPPORTED_RATE;
            end
        endcase
        exp_rate   = r;
        exp_fcs_ok = 1'b0;
    endtask

    // one to three idle cycles before each byte
    task automatic send_byte(input logic [BYTE_W-1:0] b);
        repeat (rand_range(1, 3)) @(posedge clock);
        #2;
        byte_i        = b;
        byte_strobe_i = 1'b1;
        @(posedge clock);
        #2;
        byte_strobe_i = 1'b0;
    endtask

    task automatic send_packet();
        @(posedge clock);
        #2;
        pkt_start_i = 1'b1;
        @(posedge clock);
        #2;
        pkt_start_i = 1'b0;
        for (int i = 0; i < SIG_BYTES; i++) begin
            send_byte(tx_signal[i*8 +: 8]);
        end
        for (int i = 0; i < tx_bytes.size(); i++) begin
            send_byte(tx_bytes[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response checking
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_symbols();
        int cnt;
        cnt = 0;
        @(negedge clock);
        check_flag("phy_len_valid_o", 1'b0, phy_len_valid_o);
        while (!phy_len_valid_o) begin
            if (cnt == TIMEOUT) begin
                stop_on_error("timeout waiting for the symbol count to become valid");
            end else begin
                cnt++;
                @(negedge clock);
            end
        end
        check_nsym("n_ofdm_sym_o", ref_nsym(exp_rate, exp_len), n_ofdm_sym_o);
        check_nbits("n_bit_in_last_sym_o", ref_last_bits(exp_rate, exp_len),
                    n_bit_in_last_sym_o);
    endtask

    task automatic check_payload();
        int   cnt;
        int   idx;
        logic done;
        cnt  = 0;
        idx  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clock);
            if (cnt == TIMEOUT) begin
                stop_on_error("timeout waiting for a payload byte or the FCS verdict");
            end else if (data_strobe_o && idx >= tx_bytes.size()) begin
                stop_on_error("more payload bytes were forwarded than sent");
            end else begin
                cnt++;
                if (data_strobe_o) begin
                    check_byte("data_o", tx_bytes[idx], data_o);
                    idx++;
                    cnt = 0;
                    check_len("byte_count_o", LEN_W'(idx), byte_count_o);
                end
                if (fcs_out_strobe_o) begin
                    check_len("forwarded byte total", exp_len, LEN_W'(idx));
                    check_len("byte_count_o", exp_len, byte_count_o);
                    check_flag("fcs_ok_o", exp_fcs_ok, fcs_ok_o);
                    check_status("status_o", exp_fcs_ok ? E_OK : E_WRONG_FCS, status_o);
                    done = 1'b1;
                end
            end
        end
    endtask

    task automatic check_packet();
        int   cnt;
        logic hdr_ok;
        hdr_ok = (exp_hdr_status == E_OK);
        cnt    = 0;
        @(negedge clock);
        while (!pkt_header_valid_strobe_o) begin
            if (cnt == TIMEOUT) begin
                stop_on_error("timeout waiting for the header verdict");
            end else begin
                cnt++;
                @(negedge clock);
            end
        end
        check_status("status_o", exp_hdr_status, status_o);
        check_flag("demod_is_ongoing_o", 1'b1, demod_is_ongoing_o);
        check_flag("legacy_sig_stb_o", hdr_ok, legacy_sig_stb_o);
        check_flag("pkt_header_valid_o", hdr_ok, pkt_header_valid_o);
        if (hdr_ok) begin
            check_rate("pkt_rate_o", exp_rate, pkt_rate_o);
            check_len("pkt_len_o", exp_len, pkt_len_o);
            fork
                check_symbols();
                check_payload();
            join
        end
        // receiver must return to idle
        cnt = 0;
        while (demod_is_ongoing_o) begin
            if (cnt == TIMEOUT) begin
                stop_on_error("timeout waiting for the receiver to go idle");
            end else begin
                cnt++;
                @(negedge clock);
            end
        end
    endtask

    task automatic run_packet();
        fork
            send_packet();
            check_packet();
        join
        repeat (4) @(posedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        seed            = 26;
        equalizer_reset = 1'b1;
        pkt_start_i     = 1'b0;
        byte_strobe_i   = 1'b0;
        byte_i          = '0;
        repeat (4) @(posedge clock);
        #2;
        equalizer_reset = 1'b0;
        @(negedge clock);
        check_flag("demod_is_ongoing_o", 1'b0, demod_is_ongoing_o);
        check_flag("pkt_header_valid_o", 1'b0, pkt_header_valid_o);
        check_flag("data_strobe_o", 1'b0, data_strobe_o);
        check_flag("phy_len_valid_o", 1'b0, phy_len_valid_o);

        // every supported rate, clean frame
        for (int i = 0; i < N_RATES; i++) begin
            make_good_frame(rate_at(i), rand_range(4, 40), 1'b0);
            run_packet();
        end

        // broken headers, each followed by a clean frame
        for (int k = 0; k < 4; k++) begin
            make_bad_header(k);
            run_packet();
            make_good_frame(rate_at(rand_range(0, N_RATES - 1)), rand_range(4, 40), 1'b0);
            run_packet();
        end

        // one payload bit flipped
        for (int i = 0; i < 3; i++) begin
            make_good_frame(rate_at(rand_range(0, N_RATES - 1)), rand_range(4, 40), 1'b1);
            run_packet();
        end

        $display("test passed");
        $finish;
    end

endmodule

/* dot11_rx.f */
+incdir+bench
hdl/dot11_rx_pkg.sv
hdl/signal_field_check.sv
hdl/rx_frame_ctrl.sv
hdl/fcs_crc32.sv
hdl/phy_len_calc.sv
hdl/dot11_rx_top.sv
bench/dot11_rx_tb.sv

/* Bender.yml */
package:
  name: dot11_rx

sources:
  - hdl/dot11_rx_pkg.sv
  - hdl/signal_field_check.sv
  - hdl/rx_frame_ctrl.sv
  - hdl/fcs_crc32.sv
  - hdl/phy_len_calc.sv
  - hdl/dot11_rx_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/dot11_rx_tb.sv
